// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_n64_vid
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/n64_vbus_demux.sv ====
`timescale 1ns/1ns

`include "n64_vid_defs.svh"

module n64_vbus_demux
  import n64_vid_pkg::*;
(
  input  logic   VCLK,
  input  logic   nRST,
  input  logic   nVDSYNC,
  input  color_t vdata,
  output sync_t  sync_pre,
  output sync_t  sync_cur,
  output rgb_t   pixel,
  output logic   pixel_valid
);

  // slot of the bus word after the sync word
  // idle also marks the sync slot, counter saturates there
  localparam logic [1:0] ph_red   = 2'd0;
  localparam logic [1:0] ph_green = 2'd1;
  localparam logic [1:0] ph_blue  = 2'd2;
  localparam logic [1:0] ph_idle  = 2'd3;

  logic [1:0] phase;
  color_t     red_q;
  color_t     green_q;
  logic       blue_slot;

  // blue word on the bus completes the pixel
  assign blue_slot = nVDSYNC & (phase == ph_blue);

  ////////////////////////////////////////
  // sync history

  // reset to all inactive so the first real nibble gives no false edge
  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST) begin
      sync_pre <= '1;
      sync_cur <= '1;
    end else if (!nVDSYNC) begin
      sync_pre <= sync_cur;
      sync_cur <= vdata[`N64_SYNC_W-1:0];
    end
  end

  ////////////////////////////////////////
  // colour slots

  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST) begin
      phase <= ph_idle;
    end else if (!nVDSYNC) begin
      phase <= ph_red;
    end else if (phase != ph_idle) begin
      phase <= phase + 2'd1;
    end
  end

  // holding registers for red and green, pixel published on blue
  always_ff @(posedge VCLK) begin
    if (nVDSYNC && (phase == ph_red)) begin
      red_q <= vdata;
    end
    if (nVDSYNC && (phase == ph_green)) begin
      green_q <= vdata;
    end
    if (blue_slot) begin
      pixel <= {red_q, green_q, vdata};
    end
  end

  // one cycle strobe alongside the new pixel
  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST) begin
      pixel_valid <= 1'b0;
    end else begin
      pixel_valid <= blue_slot;
    end
  end

endmodule

// ==== hw/n64_vid_defs.svh ====
`ifndef N64_VID_DEFS_SVH
`define N64_VID_DEFS_SVH

// video bus widths
`define N64_COLOR_W    7
`define N64_SYNC_W     4
`define N64_RGB_W      (3 * `N64_COLOR_W)

// sync nibble bit positions, all sync signals active low
`define N64_SYNC_VS    3
`define N64_SYNC_HS    1

// vinfo is {palmode, n64_480i}
`define VINFO_W        2
// NTSC, interlaced
`define VINFO_RST      2'b01

// wishbone side
`define WB_DW          32
`define REG_AW         2

// register word addresses
`define REG_STATUS     2'd0
`define REG_MODE_CHG   2'd1
`define REG_SNAP_CTRL  2'd2
`define REG_PIXEL      2'd3

// bit positions inside the registers
`define STAT_SNAP_DONE 2
`define SNAP_ARM_BIT   0

`endif

// ==== hw/n64_vid_pkg.sv ====
package n64_vid_pkg;

`include "n64_vid_defs.svh"

  // one colour sample, also the raw 7 bit bus word
  typedef logic [`N64_COLOR_W-1:0] color_t;

  // nVSYNC, nCLAMP, nHSYNC, nCSYNC from high to low
  typedef logic [`N64_SYNC_W-1:0] sync_t;

  // red in the top bits, blue in the bottom bits
  typedef logic [`N64_RGB_W-1:0] rgb_t;

  // palmode high, n64_480i low
  typedef logic [`VINFO_W-1:0] vinfo_t;

  // wishbone data word
  typedef logic [`WB_DW-1:0] wb_data_t;

  // register word address
  typedef logic [`REG_AW-1:0] reg_addr_t;

  // pixel snapshot sequence in the register slave
  typedef enum logic [1:0] {
    snap_idle,
    snap_armed,
    snap_done
  } snap_state_t;

endpackage

// ==== hw/n64_vid_top.sv ====
`timescale 1ns/1ns

module n64_vid_top
  import n64_vid_pkg::*;
(
  input  logic      VCLK,
  input  logic      nRST,
  input  logic      nVDSYNC,
  input  color_t    vdata,
  input  logic      wb_cyc,
  input  logic      wb_stb,
  input  logic      wb_we,
  input  reg_addr_t wb_adr,
  input  wb_data_t  wb_dat_w,
  output wb_data_t  wb_dat_r,
  output logic      wb_ack
);

  // sync history and pixels from the demux
  sync_t  sync_pre;
  sync_t  sync_cur;
  rgb_t   pixel;
  logic   pixel_valid;
  // mode flags from the extractor
  vinfo_t vinfo;

  n64_vbus_demux demux0 (
    .VCLK        (VCLK),
    .nRST        (nRST),
    .nVDSYNC     (nVDSYNC),
    .vdata       (vdata),
    .sync_pre    (sync_pre),
    .sync_cur    (sync_cur),
    .pixel       (pixel),
    .pixel_valid (pixel_valid)
  );

  // reads the raw nVDSYNC to pick the sync slots
  n64_vinfo_ext vinfo0 (
    .VCLK     (VCLK),
    .nRST     (nRST),
    .nVDSYNC  (nVDSYNC),
    .sync_pre (sync_pre),
    .sync_cur (sync_cur),
    .vinfo    (vinfo)
  );

  n64_vinfo_regs regs0 (
    .VCLK        (VCLK),
    .nRST        (nRST),
    .vinfo       (vinfo),
    .pixel       (pixel),
    .pixel_valid (pixel_valid),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack)
  );

endmodule

// ==== hw/n64_vinfo_ext.sv ====
`timescale 1ns/1ns

`include "n64_vid_defs.svh"

module n64_vinfo_ext
  import n64_vid_pkg::*;
(
  input  logic   VCLK,
  input  logic   nRST,
  input  logic   nVDSYNC,
  input  sync_t  sync_pre,
  input  sync_t  sync_cur,
  output vinfo_t vinfo
);

  logic vs_rise;
  logic vs_fall;
  logic hs_rise;
  logic hs_fall;

  // 1 for odd frame, 0 for even frame
  logic       frame_odd;
  // 1 while frames alternate between odd and even
  logic       n64_480i;
  // low two bits of the line count since the last vsync
  logic [1:0] line_cnt;
  // 1 for PAL, 0 for NTSC
  logic       palmode;

  ////////////////////////////////////////
  // sync edges from the nibble history

  assign vs_rise = ~sync_pre[`N64_SYNC_VS] &  sync_cur[`N64_SYNC_VS];
  assign vs_fall =  sync_pre[`N64_SYNC_VS] & ~sync_cur[`N64_SYNC_VS];
  assign hs_rise = ~sync_pre[`N64_SYNC_HS] &  sync_cur[`N64_SYNC_HS];
  assign hs_fall =  sync_pre[`N64_SYNC_HS] & ~sync_cur[`N64_SYNC_HS];

  ////////////////////////////////////////
  // progressive or interlaced

  // vsync falling together with hsync marks an odd frame
  // a change of frame type against the last frame means interlaced
  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST) begin
      frame_odd <= 1'b0;
      n64_480i  <= 1'b1;
    end else if (!nVDSYNC && vs_fall) begin
      n64_480i  <= hs_fall ^ frame_odd;
      frame_odd <= hs_fall;
    end
  end

  ////////////////////////////////////////
  // PAL or NTSC

  // NTSC fields end with line_cnt 1x, PAL fields with 0x
  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST) begin
      line_cnt <= 2'd0;
      palmode  <= 1'b0;
    end else if (!nVDSYNC) begin
      if (vs_rise) begin
        palmode  <= ~line_cnt[1];
        line_cnt <= 2'd0;
      end else if (hs_rise) begin
        line_cnt <= line_cnt + 2'd1;
      end
    end
  end

  assign vinfo = {palmode, n64_480i};

endmodule

// ==== hw/n64_vinfo_regs.sv ====
`timescale 1ns/1ns

`include "n64_vid_defs.svh"

module n64_vinfo_regs
  import n64_vid_pkg::*;
(
  input  logic      VCLK,
  input  logic      nRST,
  input  vinfo_t    vinfo,
  input  rgb_t      pixel,
  input  logic      pixel_valid,
  input  logic      wb_cyc,
  input  logic      wb_stb,
  input  logic      wb_we,
  input  reg_addr_t wb_adr,
  input  wb_data_t  wb_dat_w,
  output wb_data_t  wb_dat_r,
  output logic      wb_ack
);

  logic        wb_req;
  logic        wb_wr;
  logic        chg_clr;
  logic        snap_wr;
  vinfo_t      vinfo_q;
  wb_data_t    mode_chg;
  snap_state_t snap_state;
  snap_state_t snap_next;
  rgb_t        snap_pixel;
  wb_data_t    rd_data;

  ////////////////////////////////////////
  // wishbone classic handshake

  // stb is still high in the ack cycle, so mask it to get a single ack
  assign wb_req  = wb_cyc & wb_stb & ~wb_ack;
  assign wb_wr   = wb_req & wb_we;
  assign chg_clr = wb_wr & (wb_adr == `REG_MODE_CHG);
  assign snap_wr = wb_wr & (wb_adr == `REG_SNAP_CTRL);

  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_req;
    end
  end

  // read mux, unmapped bits stay 0
  always_comb begin
    rd_data = '0;
    case (wb_adr)
      `REG_STATUS: begin
        rd_data[`VINFO_W-1:0]    = vinfo;
        rd_data[`STAT_SNAP_DONE] = (snap_state == snap_done);
      end
      `REG_MODE_CHG: begin
        rd_data = mode_chg;
      end
      `REG_SNAP_CTRL: begin
        rd_data[`SNAP_ARM_BIT] = (snap_state == snap_armed);
      end
      `REG_PIXEL: begin
        rd_data[`N64_RGB_W-1:0] = snap_pixel;
      end
      default: begin
        rd_data = '0;
      end
    endcase
  end

  // data sampled with the request, valid during ack
  always_ff @(posedge VCLK) begin
    if (wb_req) begin
      wb_dat_r <= rd_data;
    end
  end

  ////////////////////////////////////////
  // mode change counter

  // any write to MODE_CHG wins over a change in the same cycle
  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST) begin
      vinfo_q  <= `VINFO_RST;
      mode_chg <= '0;
    end else begin
      vinfo_q <= vinfo;
      if (chg_clr) begin
        mode_chg <= '0;
      end else if (vinfo != vinfo_q) begin
        mode_chg <= mode_chg + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // pixel snapshot

  // writing SNAP_CTRL bit 0 as 1 arms, as 0 returns to idle
  always_comb begin
    snap_next = snap_state;
    case (snap_state)
      snap_armed: begin
        if (pixel_valid) begin
          snap_next = snap_done;
        end
      end
      snap_idle, snap_done: begin
        snap_next = snap_state;
      end
      default: begin
        snap_next = snap_idle;
      end
    endcase
    if (snap_wr) begin
      snap_next = wb_dat_w[`SNAP_ARM_BIT] ? snap_armed : snap_idle;
    end
  end

  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST) begin
      snap_state <= snap_idle;
    end else begin
      snap_state <= snap_next;
    end
  end

  // capture the pixel that completes the armed state
  always_ff @(posedge VCLK) begin
    if ((snap_state == snap_armed) && (snap_next == snap_done)) begin
      snap_pixel <= pixel;
    end
  end

endmodule

// ==== src.f ====
+incdir+hw
hw/n64_vid_pkg.sv
hw/n64_vbus_demux.sv
hw/n64_vinfo_ext.sv
hw/n64_vinfo_regs.sv
hw/n64_vid_top.sv
verification/tb_n64_vid.sv

// ==== verification/tb_n64_vid.sv ====
`timescale 1ns/1ns

`include "n64_vid_defs.svh"

module tb_n64_vid
  import n64_vid_pkg::*;
();

  localparam int CLK_PERIOD   = 10;
  localparam int NTSC_LINES   = 263;
  localparam int PAL_LINES    = 313;
  // one line is 4 pixels of 4 bus words each
  localparam int CYC_PER_LINE = 16;
  // all fields driven by tests 2 to 6
  localparam int FIELD_LINES  = 8 * NTSC_LINES + 9 * PAL_LINES;
  localparam int WATCHDOG_NS  = FIELD_LINES * CYC_PER_LINE * 2 * CLK_PERIOD;
  localparam int ACK_LIMIT    = 8;

  logic      VCLK;
  logic      nRST;
  logic      nVDSYNC;
  color_t    vdata;
  logic      wb_cyc;
  logic      wb_stb;
  logic      wb_we;
  reg_addr_t wb_adr;
  wb_data_t  wb_dat_w;
  wb_data_t  wb_dat_r;
  logic      wb_ack;

  // bookkeeping
  string cur_test;
  int    tests_run;
  int    tests_failed;
  int    checks;
  int    test_errs;
  int    total_errs;

  // reference model state, history of the last field
  int     hist_lines;
  bit     hist_odd;
  vinfo_t exp_vinfo;
  int     exp_chg;

  n64_vid_top dut0 (
    .VCLK     (VCLK),
    .nRST     (nRST),
    .nVDSYNC  (nVDSYNC),
    .vdata    (vdata),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  always #(CLK_PERIOD / 2) VCLK = ~VCLK;

  ////////////////////////////////////////
  // reference and compare

  // palmode from the line count of the field before, n64_480i from the frame type change
  function automatic vinfo_t expect_vinfo(input int prev_lines, input bit prev_odd,
                                          input bit cur_odd);
    bit pal;
    pal = (prev_lines % 4) < 2;
    return {pal, prev_odd ^ cur_odd};
  endfunction

  task automatic note_error();
    test_errs++;
    total_errs++;
  endtask

  task automatic check_vinfo(input string name, input vinfo_t got, input vinfo_t exp);
    checks++;
    if (got !== exp) begin
      $display("error %s: got %h, expected %h", name, got, exp);
      note_error();
    end
  endtask

  task automatic check_count(input string name, input wb_data_t got, input wb_data_t exp);
    checks++;
    if (got !== exp) begin
      $display("error %s: got %h, expected %h", name, got, exp);
      note_error();
    end
  endtask

  task automatic check_pixel(input string name, input rgb_t got, input rgb_t exp);
    checks++;
    if (got !== exp) begin
      $display("error %s: got %h, expected %h", name, got, exp);
      note_error();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("error %s: got %h, expected %h", name, got, exp);
      note_error();
    end
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
    tests_run++;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      $display("test %s: passed", cur_test);
    end else begin
      $display("test %s: failed with %0d errors", cur_test, test_errs);
      tests_failed++;
    end
  endtask

  ////////////////////////////////////////
  // video field generator

  // hsync low on pixel 0 of each line
  // odd fields drop vsync with hsync, even fields two pixels later
  function automatic sync_t sync_word(input int line, input int pix, input bit odd);
    logic vs_n;
    logic hs_n;
    hs_n = (pix != 0);
    if (odd) begin
      vs_n = !((line == 0) && (pix < 2));
    end else begin
      vs_n = !((line == 0) && (pix >= 2));
    end
    // nVSYNC, nCLAMP, nHSYNC, nCSYNC
    return {vs_n, 1'b1, hs_n, vs_n & hs_n};
  endfunction

  // one bus word, driven just after the clock edge
  task automatic drive_word(input logic sync_n, input color_t word);
    @(posedge VCLK);
    #1;
    nVDSYNC = sync_n;
    vdata   = word;
  endtask

  task automatic drive_field(input int lines, input bit odd, input bit fixed, input rgb_t rgb);
    color_t col;
    sync_t  nib;
    for (int line = 0; line < lines; line++) begin
      for (int pix = 0; pix < 4; pix++) begin
        nib = sync_word(line, pix, odd);
        drive_word(1'b0, {3'b000, nib});
        // red, green, blue
        for (int c = 0; c < 3; c++) begin
          if (fixed) begin
            col = rgb[`N64_RGB_W-1-c*`N64_COLOR_W -: `N64_COLOR_W];
          end else begin
            col = color_t'($urandom);
          end
          drive_word(1'b1, col);
        end
      end
    end
  endtask

  ////////////////////////////////////////
  // wishbone master

  task automatic bus_transfer(input bit we, input reg_addr_t adr, input wb_data_t wdat,
                              output wb_data_t rdat);
    int   waited;
    logic got_ack;
    @(posedge VCLK);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    waited   = 0;
    got_ack  = 1'b0;
    while (!got_ack && (waited < ACK_LIMIT)) begin
      @(posedge VCLK);
      #1;
      waited++;
      got_ack = wb_ack;
    end
    rdat = wb_dat_r;
    if (!got_ack) begin
      $display("bus transfer to register %0d got no ack", adr);
      note_error();
    end else if (waited != 1) begin
      $display("ack came %0d cycles after the request instead of 1", waited);
      note_error();
    end
    // stb stays up through the ack cycle and drops in the cycle after it
    @(posedge VCLK);
    #1;
    if (wb_ack) begin
      $display("ack stayed high for more than one cycle");
      note_error();
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic reg_read(input reg_addr_t adr, output wb_data_t rdat);
    bus_transfer(1'b0, adr, '0, rdat);
  endtask

  task automatic reg_write(input reg_addr_t adr, input wb_data_t wdat);
    wb_data_t unused;
    bus_transfer(1'b1, adr, wdat, unused);
  endtask

  // one field, then the model steps and STATUS is compared
  task automatic run_field(input int lines, input bit odd, input bit fixed, input rgb_t rgb);
    vinfo_t   nxt;
    wb_data_t rd;
    drive_field(lines, odd, fixed, rgb);
    nxt        = expect_vinfo(hist_lines, hist_odd, odd);
    // flag bits move on different sync words, so each changed bit counts once
    exp_chg    = exp_chg + $countones(nxt ^ exp_vinfo);
    exp_vinfo  = nxt;
    hist_lines = lines;
    hist_odd   = odd;
    reg_read(`REG_STATUS, rd);
    check_vinfo("STATUS.vinfo", rd[`VINFO_W-1:0], exp_vinfo);
  endtask

  ////////////////////////////////////////
  // watchdog

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within the watchdog limit");
    $display("SOME TESTS FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // test sequence

  initial begin
    wb_data_t rd;
    rgb_t     snap_rgb;
    VCLK         = 1'b0;
    nRST         = 1'b0;
    nVDSYNC      = 1'b1;
    vdata        = '0;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat_w     = '0;
    tests_run    = 0;
    tests_failed = 0;
    checks       = 0;
    test_errs    = 0;
    total_errs   = 0;
    void'($urandom(32'h7904_3543));
    // the first field sees one hsync pulse before its vsync ends
    // and the frame type register starts as even
    hist_lines = 1;
    hist_odd   = 1'b0;
    exp_vinfo  = `VINFO_RST;
    exp_chg    = 0;
    repeat (3) @(posedge VCLK);
    #1;
    nRST = 1'b1;

    start_test("1 reset values");
    reg_read(`REG_STATUS, rd);
    check_vinfo("STATUS.vinfo", rd[`VINFO_W-1:0], 2'b01);
    check_flag("STATUS.snap_done", rd[`STAT_SNAP_DONE], 1'b0);
    reg_read(`REG_MODE_CHG, rd);
    check_count("MODE_CHG", rd, '0);
    end_test();

    start_test("2 ntsc progressive");
    repeat (3) run_field(NTSC_LINES, 1'b0, 1'b0, '0);
    reg_read(`REG_STATUS, rd);
    check_vinfo("STATUS.vinfo", rd[`VINFO_W-1:0], 2'b00);
    end_test();

    start_test("3 pal interlaced");
    repeat (2) begin
      run_field(PAL_LINES, 1'b1, 1'b0, '0);
      run_field(PAL_LINES, 1'b0, 1'b0, '0);
    end
    reg_read(`REG_STATUS, rd);
    check_vinfo("STATUS.vinfo", rd[`VINFO_W-1:0], 2'b11);
    end_test();

    start_test("4 mode change counter");
    reg_read(`REG_MODE_CHG, rd);
    check_count("MODE_CHG", rd, wb_data_t'(exp_chg));
    run_field(NTSC_LINES, 1'b1, 1'b0, '0);
    run_field(PAL_LINES, 1'b1, 1'b0, '0);
    run_field(NTSC_LINES, 1'b0, 1'b0, '0);
    run_field(PAL_LINES, 1'b1, 1'b0, '0);
    run_field(NTSC_LINES, 1'b0, 1'b0, '0);
    reg_read(`REG_MODE_CHG, rd);
    check_count("MODE_CHG", rd, wb_data_t'(exp_chg));
    reg_write(`REG_MODE_CHG, '0);
    exp_chg = 0;
    reg_read(`REG_MODE_CHG, rd);
    check_count("MODE_CHG", rd, '0);
    end_test();

    start_test("5 pixel snapshot");
    snap_rgb = rgb_t'($urandom);
    reg_write(`REG_SNAP_CTRL, 32'h1);
    reg_read(`REG_SNAP_CTRL, rd);
    check_flag("SNAP_CTRL.armed", rd[`SNAP_ARM_BIT], 1'b1);
    reg_read(`REG_STATUS, rd);
    check_flag("STATUS.snap_done", rd[`STAT_SNAP_DONE], 1'b0);
    run_field(PAL_LINES, 1'b0, 1'b1, snap_rgb);
    reg_read(`REG_STATUS, rd);
    check_flag("STATUS.snap_done", rd[`STAT_SNAP_DONE], 1'b1);
    reg_read(`REG_SNAP_CTRL, rd);
    check_flag("SNAP_CTRL.armed", rd[`SNAP_ARM_BIT], 1'b0);
    reg_read(`REG_PIXEL, rd);
    check_pixel("PIXEL", rd[`N64_RGB_W-1:0], snap_rgb);
    end_test();

    start_test("6 interlaced to progressive");
    run_field(NTSC_LINES, 1'b1, 1'b0, '0);
    run_field(PAL_LINES, 1'b0, 1'b0, '0);
    reg_read(`REG_STATUS, rd);
    check_flag("STATUS.n64_480i", rd[0], 1'b1);
    run_field(NTSC_LINES, 1'b0, 1'b0, '0);
    run_field(PAL_LINES, 1'b0, 1'b0, '0);
    reg_read(`REG_STATUS, rd);
    check_flag("STATUS.n64_480i", rd[0], 1'b0);
    reg_read(`REG_MODE_CHG, rd);
    check_count("MODE_CHG", rd, wb_data_t'(exp_chg));
    end_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, total_errs);
    if (total_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
